// ==== hdl/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

	// Cache geometry
	localparam int NUM_WAYS   = 4;
	localparam int NUM_SETS   = 16;
	localparam int ADDR_W     = 32;
	localparam int TAG_W      = 22;
	localparam int INDEX_W    = 4;
	localparam int OFFSET_W   = 6;
	localparam int LINE_BYTES = 64;
	localparam int LINE_W     = 512;
	localparam int WORD_W     = 32;
	localparam int WORD_SEL_W = 4;		// One of 16 words in a line

	typedef logic [1:0] way_t;
	typedef logic [1:0] lru_status_t;	// 0 invalid, 3 most recent

	typedef struct packed {
		logic [TAG_W-1:0]    tag;
		logic [INDEX_W-1:0]  index;
		logic [OFFSET_W-1:0] offset;
	} cache_addr_s;

	// Address seen as a plain word or split into fields
	typedef union packed {
		logic [ADDR_W-1:0] raw;
		cache_addr_s       f;
	} cache_addr_u;

	typedef struct packed {
		lru_status_t      status;	// Upper bits, as in the tag RAM word
		logic [TAG_W-1:0] tag;
	} tag_entry_s;

	typedef logic [LINE_W-1:0]     line_t;
	typedef logic [LINE_BYTES-1:0] byte_en_t;

	typedef enum logic [1:0] {
		BYTE = 2'd0,
		HALF = 2'd1,
		WORD = 2'd2,
		NONE = 2'd3
	} store_size_e;

	typedef struct packed {
		logic hit;
		way_t way;
	} lookup_s;

	typedef struct packed {
		cache_addr_u addr;
		line_t       line;
	} fill_req_s;

	typedef struct packed {
		cache_addr_u       addr;
		store_size_e       size;
		logic [WORD_W-1:0] data;
	} store_req_s;

	// Write command into the data array
	typedef struct packed {
		logic               en;
		way_t               way;
		logic [INDEX_W-1:0] index;
		byte_en_t           byte_en;
		line_t              data;
	} line_wr_s;

endpackage

`default_nettype wire

// ==== hdl/dcache_tag_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_array #(
	parameter int AGE_TIMER_WIDTH = 16
) (
	input  logic                    iCLOCK,
	input  logic                    inRESET,
	input  logic                    flush,
	input  logic                    rd_accept,
	input  dcache_pkg::cache_addr_u rd_addr,
	input  logic                    st_req,
	input  dcache_pkg::store_req_s  store,
	input  logic                    fill_go,
	input  dcache_pkg::fill_req_s   fill,
	output dcache_pkg::lookup_s     rd_lookup,
	output dcache_pkg::lookup_s     st_lookup,
	output dcache_pkg::way_t        fill_way
);
	import dcache_pkg::*;

	tag_entry_s                 tags [NUM_WAYS][NUM_SETS];
	logic [AGE_TIMER_WIDTH-1:0] b_age_timer;
	logic                       age_wrap;
	logic                       rd_hit_go;

	// Lowest valid way holding the tag
	function automatic lookup_s find_hit(
		input logic [TAG_W-1:0]   tag,
		input logic [INDEX_W-1:0] idx
	);
		lookup_s res;
		res = '0;
		for (int w = NUM_WAYS - 1; w >= 0; w--) begin
			if (tags[w][idx].tag == tag && tags[w][idx].status != 2'd0) begin
				res.hit = 1'b1;
				res.way = way_t'(w);
			end
		end
		return res;
	endfunction

	// Same tag first, otherwise the least recent status
	function automatic way_t pick_victim(
		input logic [TAG_W-1:0]   tag,
		input logic [INDEX_W-1:0] idx
	);
		way_t res;
		res = way_t'(NUM_WAYS - 1);		// Every way at status 3
		for (int lvl = 2; lvl >= 0; lvl--) begin
			for (int w = NUM_WAYS - 1; w >= 0; w--) begin
				if (tags[w][idx].status == lru_status_t'(lvl)) begin
					res = way_t'(w);
				end
			end
		end
		for (int w = NUM_WAYS - 1; w >= 0; w--) begin
			if (tags[w][idx].tag == tag) begin
				res = way_t'(w);
			end
		end
		return res;
	endfunction

	function automatic lru_status_t age(input lru_status_t s);
		return (s >= 2'd2) ? s - 2'd1 : s;	// 1 stays, invalid stays
	endfunction

	always_comb begin
		rd_lookup = find_hit(rd_addr.f.tag, rd_addr.f.index);
		st_lookup = find_hit(store.addr.f.tag, store.addr.f.index);
		fill_way  = pick_victim(fill.addr.f.tag, fill.addr.f.index);
	end

	assign age_wrap  = &b_age_timer;
	assign rd_hit_go = rd_accept && rd_lookup.hit;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_age_timer <= '0;
			for (int s = 0; s < NUM_SETS; s++) begin
				for (int w = 0; w < NUM_WAYS; w++) begin
					tags[w][s].status <= '0;
				end
			end
		end
		else if (flush) begin
			b_age_timer <= '0;
			for (int s = 0; s < NUM_SETS; s++) begin
				for (int w = 0; w < NUM_WAYS; w++) begin
					tags[w][s].status <= '0;	// Invalidate all lines
				end
			end
		end
		else begin
			b_age_timer <= b_age_timer + 1'b1;
			if (st_req && st_lookup.hit) begin
				// Store bumps the hit way, saturating
				if (tags[st_lookup.way][store.addr.f.index].status != 2'd3) begin
					tags[st_lookup.way][store.addr.f.index].status <=
						tags[st_lookup.way][store.addr.f.index].status + 2'd1;
				end
			end
			else if (fill_go) begin
				tags[fill_way][fill.addr.f.index] <= '{status: 2'd3, tag: fill.addr.f.tag};
			end
			else begin
				for (int s = 0; s < NUM_SETS; s++) begin
					for (int w = 0; w < NUM_WAYS; w++) begin
						if (rd_hit_go && s == rd_addr.f.index && w == rd_lookup.way) begin
							tags[w][s].status <= 2'd3;		// Read hit is most recent
						end
						else if (age_wrap) begin
							tags[w][s].status <= age(tags[w][s].status);
						end
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/dcache_data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_data_array (
	input  logic                                iCLOCK,
	input  dcache_pkg::line_wr_s                line_wr,
	input  logic [dcache_pkg::INDEX_W-1:0]      rd_index,
	output dcache_pkg::line_t                   rd_line [dcache_pkg::NUM_WAYS]
);
	import dcache_pkg::*;

	// One line RAM per way, byte enables on the write side
	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		line_t mem [NUM_SETS];
		logic  way_we;

		assign way_we = line_wr.en && (line_wr.way == way_t'(w));

		always_ff @(posedge iCLOCK) begin
			if (way_we) begin
				for (int b = 0; b < LINE_BYTES; b++) begin
					if (line_wr.byte_en[b]) begin
						mem[line_wr.index][b*8 +: 8] <= line_wr.data[b*8 +: 8];
					end
				end
			end
		end

		assign rd_line[w] = mem[rd_index];	// No read latency
	end

endmodule

`default_nettype wire

// ==== hdl/dcache_line_write.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_line_write (
	input  logic                   st_req,
	input  dcache_pkg::store_req_s store,
	input  dcache_pkg::lookup_s    st_lookup,
	input  logic                   fill_req,
	input  dcache_pkg::fill_req_s  fill,
	input  dcache_pkg::way_t       fill_way,
	output logic                   fill_busy,
	output logic                   fill_go,
	output dcache_pkg::line_wr_s   line_wr
);
	import dcache_pkg::*;

	logic st_go;

	// Byte lanes touched by a store, aligned down to its size
	function automatic byte_en_t store_byte_en(
		input store_size_e         size,
		input logic [OFFSET_W-1:0] offset
	);
		byte_en_t be;
		case (size)
			BYTE: be = byte_en_t'(1) << offset;
			HALF: be = byte_en_t'(2'b11) << {offset[OFFSET_W-1:1], 1'b0};
			WORD: be = byte_en_t'(4'hF) << {offset[OFFSET_W-1:2], 2'b00};
			NONE: be = '0;
		endcase
		return be;
	endfunction

	assign fill_busy = st_req;		// Stores always win
	assign st_go     = st_req && st_lookup.hit;
	assign fill_go   = fill_req && !fill_busy;

	always_comb begin
		line_wr = '0;
		if (st_go) begin
			line_wr.en      = 1'b1;
			line_wr.way     = st_lookup.way;
			line_wr.index   = store.addr.f.index;
			line_wr.byte_en = store_byte_en(store.size, store.addr.f.offset);
			line_wr.data    = {(LINE_W / WORD_W){store.data}};	// Word on every lane
		end
		else if (fill_go) begin
			line_wr.en      = 1'b1;
			line_wr.way     = fill_way;
			line_wr.index   = fill.addr.f.index;
			line_wr.byte_en = '1;		// Whole line
			line_wr.data    = fill.line;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/dcache_read_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_read_port (
	input  logic                             iCLOCK,
	input  logic                             inRESET,
	input  logic                             flush,
	input  logic                             rd_req,
	input  dcache_pkg::cache_addr_u          rd_addr,
	input  logic                             rd_stall,
	input  logic                             fill_req,
	input  dcache_pkg::fill_req_s            fill,
	input  dcache_pkg::lookup_s              rd_lookup,
	input  dcache_pkg::line_t                rd_line [dcache_pkg::NUM_WAYS],
	output logic                             rd_busy,
	output logic                             rd_accept,
	output logic [dcache_pkg::INDEX_W-1:0]   rd_index,
	output logic                             rd_valid,
	output logic                             rd_hit,
	output logic [dcache_pkg::WORD_W-1:0]    rd_data
);
	import dcache_pkg::*;

	logic                  b_valid;
	logic                  b_hit;
	way_t                  b_way;
	cache_addr_u           b_addr;
	logic                  same_line;
	logic [WORD_SEL_W-1:0] word_sel;

	// Tag and index match, offset ignored
	assign same_line = rd_addr.raw[ADDR_W-1:OFFSET_W] == fill.addr.raw[ADDR_W-1:OFFSET_W];
	assign rd_busy   = rd_stall || (rd_req && fill_req && same_line);
	assign rd_accept = rd_req && !rd_busy;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_valid <= 1'b0;
			b_hit   <= 1'b0;
		end
		else if (flush) begin
			b_valid <= 1'b0;
			b_hit   <= 1'b0;
		end
		else if (!rd_stall) begin		// Hold result under back-pressure
			b_valid <= rd_accept;
			b_hit   <= rd_accept && rd_lookup.hit;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (rd_accept) begin
			b_way  <= rd_lookup.way;
			b_addr <= rd_addr;
		end
	end

	assign rd_index = b_addr.f.index;	// Data RAM follows the held request
	assign word_sel = b_addr.f.offset[OFFSET_W-1:2];

	assign rd_valid = b_valid && !rd_stall;
	assign rd_hit   = rd_valid && b_hit;
	assign rd_data  = rd_hit ? rd_line[b_way][word_sel * WORD_W +: WORD_W] : '0;

endmodule

`default_nettype wire

// ==== hdl/l1_dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1_dcache #(
	parameter int AGE_TIMER_WIDTH = 16
) (
	input  logic                          iCLOCK,
	input  logic                          inRESET,
	input  logic                          flush,
	// Read lookup
	input  logic                          rd_req,
	output logic                          rd_busy,
	input  dcache_pkg::cache_addr_u       rd_addr,
	input  logic                          rd_stall,
	output logic                          rd_valid,
	output logic                          rd_hit,
	output logic [dcache_pkg::WORD_W-1:0] rd_data,
	// Line fill
	input  logic                          fill_req,
	output logic                          fill_busy,
	input  dcache_pkg::fill_req_s         fill,
	// Store update
	input  logic                          st_req,
	input  dcache_pkg::store_req_s        store
);
	import dcache_pkg::*;

	logic               rd_accept;
	logic [INDEX_W-1:0] rd_index;
	logic               fill_go;
	line_wr_s           line_wr;
	lookup_s            rd_lookup;
	lookup_s            st_lookup;
	way_t               fill_way;
	line_t              rd_line [NUM_WAYS];

	dcache_tag_array #(
		.AGE_TIMER_WIDTH (AGE_TIMER_WIDTH)
	) u_tag (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.flush     (flush),
		.rd_accept (rd_accept),
		.rd_addr   (rd_addr),
		.st_req    (st_req),
		.store     (store),
		.fill_go   (fill_go),
		.fill      (fill),
		.rd_lookup (rd_lookup),
		.st_lookup (st_lookup),
		.fill_way  (fill_way)
	);

	dcache_data_array u_data (
		.iCLOCK   (iCLOCK),
		.line_wr  (line_wr),
		.rd_index (rd_index),
		.rd_line  (rd_line)
	);

	dcache_line_write u_write (
		.st_req    (st_req),
		.store     (store),
		.st_lookup (st_lookup),
		.fill_req  (fill_req),
		.fill      (fill),
		.fill_way  (fill_way),
		.fill_busy (fill_busy),
		.fill_go   (fill_go),
		.line_wr   (line_wr)
	);

	dcache_read_port u_read (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.flush     (flush),
		.rd_req    (rd_req),
		.rd_addr   (rd_addr),
		.rd_stall  (rd_stall),
		.fill_req  (fill_req),
		.fill      (fill),
		.rd_lookup (rd_lookup),
		.rd_line   (rd_line),
		.rd_busy   (rd_busy),
		.rd_accept (rd_accept),
		.rd_index  (rd_index),
		.rd_valid  (rd_valid),
		.rd_hit    (rd_hit),
		.rd_data   (rd_data)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_l1_dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_l1_dcache;
	import dcache_pkg::*;

	localparam int TIMEOUT = 20;		// Cycles allowed per wait

	logic              iCLOCK;
	logic              inRESET;
	logic              flush;
	logic              rd_req;
	logic              rd_busy;
	cache_addr_u       rd_addr;
	logic              rd_stall;
	logic              rd_valid;
	logic              rd_hit;
	logic [WORD_W-1:0] rd_data;
	logic              fill_req;
	logic              fill_busy;
	fill_req_s         fill;
	logic              st_req;
	store_req_s        store;
	integer            seed;
	int                mismatch_count;
	int                timeout_count;

	l1_dcache #(.AGE_TIMER_WIDTH(16)) u_dut (.*);

	initial begin
		iCLOCK = 1'b0;
		forever #20 iCLOCK = ~iCLOCK;
	end

	task automatic compare_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			mismatch_count++;
			$display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic compare_word(input logic [WORD_W-1:0] got, input logic [WORD_W-1:0] exp,
			input string what);
		if (got !== exp) begin
			mismatch_count++;
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_lookup(input logic got_hit, input logic [WORD_W-1:0] got_data,
			input logic exp_hit, input logic [WORD_W-1:0] exp_data, input string what);
		compare_flag(got_hit, exp_hit, {what, " hit"});
		compare_word(got_data, exp_data, {what, " data"});
	endtask

	function automatic line_t random_line();
		line_t l;
		for (int i = 0; i < LINE_W / WORD_W; i++) begin
			l[i*WORD_W +: WORD_W] = $random(seed);
		end
		return l;
	endfunction

	function automatic cache_addr_u make_addr(input logic [TAG_W-1:0] tag,
			input logic [INDEX_W-1:0] index, input logic [OFFSET_W-1:0] offset);
		cache_addr_u a;
		a.f.tag    = tag;
		a.f.index  = index;
		a.f.offset = offset;
		return a;
	endfunction

	// Word holding the byte offset
	function automatic logic [WORD_W-1:0] line_word(input line_t l,
			input logic [OFFSET_W-1:0] offset);
		int w;
		w = int'(offset) / 4;
		return l[w*WORD_W +: WORD_W];
	endfunction

	// Expected line after a store with byte k taking store byte k mod 4
	function automatic line_t merge_store(input line_t l, input store_size_e size,
			input logic [OFFSET_W-1:0] offset, input logic [WORD_W-1:0] data);
		int len;
		int first;
		len   = (size == BYTE) ? 1 : (size == HALF) ? 2 : (size == WORD) ? 4 : 0;
		first = (len == 0) ? 0 : (int'(offset) / len) * len;
		for (int k = first; k < first + len; k++) begin
			l[k*8 +: 8] = data[(k % 4)*8 +: 8];
		end
		return l;
	endfunction

	task automatic fill_line(input cache_addr_u addr, input line_t line);
		int n;
		@(negedge iCLOCK);
		fill_req  = 1'b1;
		fill.addr = addr;
		fill.line = line;
		#1;
		n = 0;
		while (fill_busy && n < TIMEOUT) begin
			@(negedge iCLOCK);
			#1;
			n++;
		end
		if (fill_busy) begin
			timeout_count++;
			$display("Timeout at %0t: the fill was never accepted", $time);
		end
		@(negedge iCLOCK);
		fill_req = 1'b0;
	endtask

	task automatic store_data(input cache_addr_u addr, input store_size_e size,
			input logic [WORD_W-1:0] data);
		@(negedge iCLOCK);
		st_req     = 1'b1;
		store.addr = addr;
		store.size = size;
		store.data = data;
		#1;
		compare_flag(fill_busy, 1'b1, "fill_busy during store");
		@(negedge iCLOCK);
		st_req = 1'b0;
		#1;
		compare_flag(fill_busy, 1'b0, "fill_busy after store");
	endtask

	task automatic tracked_store(input cache_addr_u addr, input store_size_e size,
			input logic [WORD_W-1:0] data, inout line_t model);
		store_data(addr, size, data);
		model = merge_store(model, size, addr.f.offset, data);
	endtask

	task automatic flush_cache(input cache_addr_u addr);
		@(negedge iCLOCK);
		flush   = 1'b1;
		rd_req  = 1'b1;		// Read taken on the flush edge
		rd_addr = addr;
		@(negedge iCLOCK);
		flush  = 1'b0;
		rd_req = 1'b0;
		compare_flag(rd_valid, 1'b0, "rd_valid after flush");
	endtask

	task automatic wait_valid(output logic seen, output int cycles);
		int n;
		n    = 0;
		seen = 1'b0;
		while (!seen && n < TIMEOUT) begin
			@(negedge iCLOCK);
			seen = rd_valid;
			n++;
		end
		cycles = n;
		if (!seen) begin
			timeout_count++;
			$display("Timeout at %0t: the read result never became valid", $time);
		end
	endtask

	task automatic read_and_expect(input cache_addr_u addr, input logic exp_hit,
			input logic [WORD_W-1:0] exp_word, input string what);
		logic seen;
		int   cycles;
		@(negedge iCLOCK);
		rd_req  = 1'b1;
		rd_addr = addr;
		wait_valid(seen, cycles);
		rd_req = 1'b0;
		if (seen) begin
			compare_flag(cycles == 1, 1'b1, {what, " valid one cycle after acceptance"});
			compare_lookup(rd_hit, rd_data, exp_hit, exp_word, what);
		end
	endtask

	// All 16 words with the low offset bits varied
	task automatic verify_line(input cache_addr_u addr, input line_t exp_line, input string what);
		cache_addr_u a;
		for (int w = 0; w < 16; w++) begin
			a          = addr;
			a.f.offset = OFFSET_W'(w * 4 + w % 4);
			read_and_expect(a, 1'b1, line_word(exp_line, a.f.offset), what);
		end
	endtask

	task automatic reset_and_flush();
		cache_addr_u a;
		line_t       ln;
		a = make_addr(22'h0ABCD, 4'd1, 6'd8);
		for (int i = 0; i < 3; i++) begin
			compare_flag(rd_valid, 1'b0, "rd_valid after reset");
			@(negedge iCLOCK);
		end
		read_and_expect(a, 1'b0, '0, "read after reset");
		ln = random_line();
		fill_line(a, ln);
		read_and_expect(a, 1'b1, line_word(ln, a.f.offset), "read after fill");
		flush_cache(a);
		read_and_expect(a, 1'b0, '0, "read after flush");
	endtask

	task automatic line_words();
		cache_addr_u a;
		cache_addr_u b;
		line_t       ln;
		a  = make_addr(22'h12345, 4'd3, 6'd0);
		ln = random_line();
		fill_line(a, ln);
		verify_line(a, ln, "filled line");
		b       = a;
		b.f.tag = 22'h12346;
		read_and_expect(b, 1'b0, '0, "other tag in same set");
	endtask

	task automatic partial_stores();
		cache_addr_u a;
		cache_addr_u m;
		line_t       ln;
		a  = make_addr(22'h2AAAA, 4'd5, 6'd0);
		ln = random_line();
		fill_line(a, ln);
		tracked_store(make_addr(22'h2AAAA, 4'd5, 6'd13), BYTE, 32'hA1B2C3D4, ln);
		tracked_store(make_addr(22'h2AAAA, 4'd5, 6'd22), HALF, 32'h11223344, ln);
		tracked_store(make_addr(22'h2AAAA, 4'd5, 6'd7), HALF, 32'h55667788, ln);
		tracked_store(make_addr(22'h2AAAA, 4'd5, 6'd41), WORD, 32'h99AABBCC, ln);
		tracked_store(make_addr(22'h2AAAA, 4'd5, 6'd63), BYTE, 32'h0F1E2D3C, ln);
		tracked_store(make_addr(22'h2AAAA, 4'd5, 6'd0), NONE, 32'hFFFFFFFF, ln);
		verify_line(a, ln, "stored line");
		m = make_addr(22'h2AAAB, 4'd5, 6'd4);		// Tag not resident
		store_data(m, WORD, 32'hDEADBEEF);
		verify_line(a, ln, "line after missed store");
		read_and_expect(m, 1'b0, '0, "absent line after store");
	endtask

	task automatic replacement();
		cache_addr_u addrs [5];
		line_t       lines [5];
		for (int i = 0; i < 5; i++) begin
			addrs[i] = make_addr(TAG_W'(22'h30000 + i), 4'd9, OFFSET_W'(i * 4));
			lines[i] = random_line();
		end
		for (int i = 0; i < 4; i++) begin
			fill_line(addrs[i], lines[i]);
		end
		for (int i = 0; i < 4; i++) begin
			read_and_expect(addrs[i], 1'b1, line_word(lines[i], addrs[i].f.offset), "four ways");
		end
		fill_line(addrs[4], lines[4]);
		read_and_expect(addrs[3], 1'b0, '0, "replaced tag");
		for (int i = 0; i < 3; i++) begin
			read_and_expect(addrs[i], 1'b1, line_word(lines[i], addrs[i].f.offset), "kept tag");
		end
		read_and_expect(addrs[4], 1'b1, line_word(lines[4], addrs[4].f.offset), "new tag");
		lines[1] = random_line();
		fill_line(addrs[1], lines[1]);		// Same tag refills its own way
		verify_line(addrs[1], lines[1], "refilled line");
		read_and_expect(addrs[0], 1'b1, line_word(lines[0], addrs[0].f.offset), "neighbour 0");
		read_and_expect(addrs[2], 1'b1, line_word(lines[2], addrs[2].f.offset), "neighbour 2");
		read_and_expect(addrs[4], 1'b1, line_word(lines[4], addrs[4].f.offset), "neighbour 4");
	endtask

	task automatic stall_and_conflict();
		cache_addr_u a;
		line_t       ln;
		logic        seen;
		int          cycles;
		a  = make_addr(22'h3C3C3, 4'd12, 6'd20);
		ln = random_line();
		fill_line(a, ln);
		@(negedge iCLOCK);
		rd_req  = 1'b1;
		rd_addr = a;
		wait_valid(seen, cycles);
		rd_req   = 1'b0;
		rd_stall = 1'b1;
		for (int i = 0; i < 3; i++) begin
			#1;
			compare_flag(rd_valid, 1'b0, "rd_valid under stall");
			compare_lookup(rd_hit, rd_data, 1'b0, '0, "result under stall");
			compare_flag(rd_busy, 1'b1, "rd_busy under stall");
			@(negedge iCLOCK);
		end
		rd_stall = 1'b0;
		#1;
		compare_flag(rd_valid, 1'b1, "rd_valid after stall");
		compare_lookup(rd_hit, rd_data, 1'b1, line_word(ln, a.f.offset), "held result");
		@(negedge iCLOCK);
		compare_flag(rd_valid, 1'b0, "rd_valid after held result");
		// Read and fill of one line in the same cycle
		ln = random_line();
		rd_req      = 1'b1;
		rd_addr     = a;
		fill_req    = 1'b1;
		fill.addr   = a;
		fill.addr.f.offset = 6'd0;
		fill.line   = ln;
		#1;
		compare_flag(rd_busy, 1'b1, "rd_busy on same-line fill");
		@(negedge iCLOCK);
		fill_req = 1'b0;
		wait_valid(seen, cycles);
		rd_req = 1'b0;
		if (seen) begin
			compare_lookup(rd_hit, rd_data, 1'b1, line_word(ln, a.f.offset), "read after fill");
		end
	endtask

	initial begin
		seed           = 65;
		mismatch_count = 0;
		timeout_count  = 0;
		inRESET        = 1'b0;
		flush          = 1'b0;
		rd_req         = 1'b0;
		rd_addr        = '0;
		rd_stall       = 1'b0;
		fill_req       = 1'b0;
		fill           = '0;
		st_req         = 1'b0;
		store          = '0;
		repeat (4) @(negedge iCLOCK);
		inRESET = 1'b1;
		reset_and_flush();
		line_words();
		partial_stores();
		replacement();
		stall_and_conflict();
		$display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
		if (mismatch_count == 0 && timeout_count == 0) begin
			$display("** PASS **");
		end
		else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
hdl/dcache_pkg.sv
hdl/dcache_tag_array.sv
hdl/dcache_data_array.sv
hdl/dcache_line_write.sv
hdl/dcache_read_port.sv
hdl/l1_dcache.sv
testbench/tb_l1_dcache.sv

// ==== Makefile ====
VERILATOR  := verilator
TOP        := tb_l1_dcache
RTL_TOP    := l1_dcache
FILELIST   := project.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := ** PASS **
FLAGS      := --binary --timing -Wno-fatal -j 0
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
